/* compile.f */
+incdir+hw
hw/line_conv_pkg.sv
hw/engine_ctrl_if.sv
hw/pe_result_if.sv
hw/engine_ctrl.sv
hw/weight_buffer.sv
hw/kernel_channel_pe.sv
hw/kcpe_array.sv
hw/result_router.sv
hw/line_conv_top.sv
verification/line_conv_sva.sv
verification/tb_line_conv.sv

/* hw/engine_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module engine_ctrl
    import line_conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i_conf_enable,
    input  tap_idx_t    i_conf_kernel_width,
    input  line_cnt_t   i_conf_line_width,
    input  line_cnt_t   i_conf_num_lines,
    input  logic        i_weight_val,
    input  logic        i_data_val,
    output logic        o_weight_req,
    output logic        o_data_req,
    output logic        o_done,
    engine_ctrl_if.ctrl ctrl_bus
);

    logic      weight_req_q;
    logic      data_req_q;
    logic      done_q;
    tap_idx_t  tap_cnt;
    line_cnt_t col_cnt;
    line_cnt_t line_cnt;
    tap_idx_t  last_tap;
    line_cnt_t last_col;
    line_cnt_t last_line;
    logic      idle;
    logic      weight_take;
    logic      pixel_take;
    logic      tap_end;
    logic      col_end;
    logic      line_end;

    ////////////////////
    // Config limits and handshake

    assign last_tap  = i_conf_kernel_width - 1'b1;
    assign last_col  = i_conf_line_width - 1'b1;
    assign last_line = i_conf_num_lines - 1'b1;

    // Nothing requested yet and not finished
    assign idle = ~(weight_req_q | data_req_q | done_q);

    // Valids only count while the matching request is up
    assign weight_take = weight_req_q & i_weight_val;
    assign pixel_take  = data_req_q & i_data_val;

    assign tap_end  = (tap_cnt == last_tap);
    assign col_end  = (col_cnt == last_col);
    assign line_end = (line_cnt == last_line);

    ////////////////////
    // Phase sequencing

    // Weight load, then data stream, then done until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            weight_req_q <= 1'b0;
            data_req_q   <= 1'b0;
            done_q       <= 1'b0;
        end else if (idle && i_conf_enable) begin
            weight_req_q <= 1'b1;
        end else if (weight_take && tap_end) begin
            weight_req_q <= 1'b0;
            data_req_q   <= 1'b1;
        end else if (pixel_take && col_end && line_end) begin
            data_req_q <= 1'b0;
            done_q     <= 1'b1;
        end
    end

    ////////////////////
    // Tap, column and line counters

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_cnt <= '0;
        end else if (weight_take) begin
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt  <= '0;
            line_cnt <= '0;
        end else if (pixel_take) begin
            if (col_end) begin
                col_cnt  <= '0;
                line_cnt <= line_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    assign ctrl_bus.weight_wr  = weight_take;
    assign ctrl_bus.weight_idx = tap_cnt;
    assign ctrl_bus.pixel_push = pixel_take;
    // Enough pixels of this line in the window for a full kernel row
    assign ctrl_bus.window_ok  = (col_cnt >= line_cnt_t'(last_tap));
    assign ctrl_bus.line_last  = col_end;

    assign o_weight_req = weight_req_q;
    assign o_data_req   = data_req_q;
    assign o_done       = done_q;

endmodule

`default_nettype wire

/* hw/engine_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface engine_ctrl_if
    import line_conv_pkg::*;
();

    // Weight load side
    logic     weight_wr;
    tap_idx_t weight_idx;

    // Pixel stream side with flags qualified by pixel_push
    logic     pixel_push;
    logic     window_ok;
    logic     line_last;

    modport ctrl (
        output weight_wr,
        output weight_idx,
        output pixel_push,
        output window_ok,
        output line_last
    );

    modport weight (
        input  weight_wr,
        input  weight_idx
    );

    modport array (
        input  pixel_push,
        input  window_ok,
        input  line_last
    );

endinterface

`default_nettype wire

/* hw/kcpe_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module kcpe_array
    import line_conv_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  pixel_vec_t                      i_data,
    input  weight_word_t [`LC_NUM_KCPE-1:0] i_pos_weight,
    engine_ctrl_if.array                    ctrl_bus,
    pe_result_if.array                      res_bus
);

    pixel_vec_t [`LC_NUM_KCPE-1:0] window_q;
    psum_vec_t  [`LC_NUM_KCPE-1:0] pos_psum;
    logic                          win_val_q;
    logic                          win_last_q;
    logic                          res_val_q;
    logic                          res_last_q;

    ////////////////////
    // Pixel window

    // Position 0 holds the newest pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            window_q <= '0;
        end else if (ctrl_bus.pixel_push) begin
            window_q[0] <= i_data;
            for (int j = 1; j < `LC_NUM_KCPE; j++) begin
                window_q[j] <= window_q[j-1];
            end
        end
    end

    for (genvar j = 0; j < `LC_NUM_KCPE; j++) begin : g_pe
        kernel_channel_pe u_pe (
            .clk      (clk),
            .rst      (rst),
            .i_pixel  (window_q[j]),
            .i_weight (i_pos_weight[j]),
            .o_psum   (pos_psum[j])
        );
    end

    ////////////////////
    // Valid pipeline

    // First stage lines up with the window, second with the PE registers
    always_ff @(posedge clk) begin
        if (rst) begin
            win_val_q  <= 1'b0;
            win_last_q <= 1'b0;
            res_val_q  <= 1'b0;
            res_last_q <= 1'b0;
        end else begin
            win_val_q  <= ctrl_bus.pixel_push & ctrl_bus.window_ok;
            win_last_q <= ctrl_bus.pixel_push & ctrl_bus.line_last;
            res_val_q  <= win_val_q;
            res_last_q <= win_last_q;
        end
    end

    assign res_bus.pos_psum = pos_psum;
    assign res_bus.res_val  = res_val_q;
    assign res_bus.res_last = res_last_q;

endmodule

`default_nettype wire

/* hw/kernel_channel_pe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module kernel_channel_pe
    import line_conv_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  pixel_vec_t   i_pixel,
    input  weight_word_t i_weight,
    output psum_vec_t    o_psum
);

    psum_vec_t mac;
    psum_vec_t psum_q;

    ////////////////////
    // Multiply-accumulate over channels

    // One dot product of 3 channel pairs per kernel
    always_comb begin
        for (int k = 0; k < `LC_NUM_KERNEL; k++) begin
            mac[k] = '0;
            for (int c = 0; c < `LC_NUM_CHANNEL; c++) begin
                mac[k] = mac[k] + psum_t'(i_weight[k][c]) * psum_t'(i_pixel[c]);
            end
        end
    end

    // Registered every cycle while the array tracks valid cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            psum_q <= '0;
        end else begin
            psum_q <= mac;
        end
    end

    assign o_psum = psum_q;

endmodule

`default_nettype wire

/* hw/line_conv_defs.svh */
`ifndef LINE_CONV_DEFS_SVH
`define LINE_CONV_DEFS_SVH

// Bits of one channel value
`define LC_PIXEL_WIDTH     8
// Channels per pixel
`define LC_NUM_CHANNEL     3
// Kernels computed side by side
`define LC_NUM_KERNEL      4
// PE positions and the widest kernel row
`define LC_NUM_KCPE        3
// Partial sum wide enough for a full window without wrap
`define LC_PSUM_WIDTH      20

// Column and line counters
`define LC_LINE_CNT_WIDTH  8
// Kernel width field and tap index
`define LC_KWIDTH_WIDTH    2

`endif

/* hw/line_conv_pkg.sv */
`default_nettype none
`include "line_conv_defs.svh"

package line_conv_pkg;

    ////////////////////
    // Data types

    typedef logic [`LC_PIXEL_WIDTH-1:0] pixel_t;

    // Channel 0 sits in the low bits
    typedef pixel_t [`LC_NUM_CHANNEL-1:0] pixel_vec_t;

    // One weight word with kernel 0 in the low bits
    typedef pixel_vec_t [`LC_NUM_KERNEL-1:0] weight_word_t;

    typedef logic [`LC_PSUM_WIDTH-1:0] psum_t;

    // One partial sum per kernel
    typedef psum_t [`LC_NUM_KERNEL-1:0] psum_vec_t;

    ////////////////////
    // Control types

    typedef logic [`LC_KWIDTH_WIDTH-1:0] tap_idx_t;
    typedef logic [`LC_LINE_CNT_WIDTH-1:0] line_cnt_t;

endpackage

`default_nettype wire

/* hw/line_conv_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module line_conv_top
    import line_conv_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_conf_enable,
    input  tap_idx_t     i_conf_kernel_width,
    input  line_cnt_t    i_conf_line_width,
    input  line_cnt_t    i_conf_num_lines,
    input  weight_word_t i_weight,
    input  logic         i_weight_val,
    input  pixel_vec_t   i_data,
    input  logic         i_data_val,
    output logic         o_weight_req,
    output logic         o_data_req,
    output psum_t        o_psum_kn0,
    output psum_t        o_psum_kn1,
    output psum_t        o_psum_kn2,
    output psum_t        o_psum_kn3,
    output logic         o_psum_val,
    output logic         o_psum_end,
    output logic         o_done
);

    weight_word_t [`LC_NUM_KCPE-1:0] pos_weight;
    psum_vec_t                       psum;

    engine_ctrl_if u_ctrl_if ();
    pe_result_if   u_res_if ();

    ////////////////////
    // Control

    engine_ctrl u_engine_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .i_conf_enable       (i_conf_enable),
        .i_conf_kernel_width (i_conf_kernel_width),
        .i_conf_line_width   (i_conf_line_width),
        .i_conf_num_lines    (i_conf_num_lines),
        .i_weight_val        (i_weight_val),
        .i_data_val          (i_data_val),
        .o_weight_req        (o_weight_req),
        .o_data_req          (o_data_req),
        .o_done              (o_done),
        .ctrl_bus            (u_ctrl_if.ctrl)
    );

    ////////////////////
    // Datapath

    weight_buffer u_weight_buffer (
        .clk          (clk),
        .rst          (rst),
        .i_weight     (i_weight),
        .ctrl_bus     (u_ctrl_if.weight),
        .o_pos_weight (pos_weight)
    );

    kcpe_array u_kcpe_array (
        .clk          (clk),
        .rst          (rst),
        .i_data       (i_data),
        .i_pos_weight (pos_weight),
        .ctrl_bus     (u_ctrl_if.array),
        .res_bus      (u_res_if.array)
    );

    result_router u_result_router (
        .clk        (clk),
        .rst        (rst),
        .res_bus    (u_res_if.router),
        .o_psum     (psum),
        .o_psum_val (o_psum_val),
        .o_psum_end (o_psum_end)
    );

    // Per-kernel output ports
    assign o_psum_kn0 = psum[0];
    assign o_psum_kn1 = psum[1];
    assign o_psum_kn2 = psum[2];
    assign o_psum_kn3 = psum[3];

endmodule

`default_nettype wire

/* hw/pe_result_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

interface pe_result_if
    import line_conv_pkg::*;
();

    // One registered psum vector per PE position
    psum_vec_t [`LC_NUM_KCPE-1:0] pos_psum;
    logic                         res_val;
    logic                         res_last;

    modport array (
        output pos_psum,
        output res_val,
        output res_last
    );

    modport router (
        input  pos_psum,
        input  res_val,
        input  res_last
    );

endinterface

`default_nettype wire

/* hw/result_router.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module result_router
    import line_conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    pe_result_if.router res_bus,
    output psum_vec_t   o_psum,
    output logic        o_psum_val,
    output logic        o_psum_end
);

    psum_vec_t pos_sum;
    psum_vec_t psum_q;
    logic      psum_val_q;
    logic      psum_end_q;

    ////////////////////
    // Position sum

    // Add the taps of every kernel across positions
    always_comb begin
        for (int k = 0; k < `LC_NUM_KERNEL; k++) begin
            pos_sum[k] = '0;
            for (int j = 0; j < `LC_NUM_KCPE; j++) begin
                pos_sum[k] = pos_sum[k] + res_bus.pos_psum[j][k];
            end
        end
    end

    // Position sums registered every cycle
    always_ff @(posedge clk) begin
        psum_q <= pos_sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            psum_val_q <= 1'b0;
            psum_end_q <= 1'b0;
        end else begin
            psum_val_q <= res_bus.res_val;
            // End marker only ever rides on a valid result
            psum_end_q <= res_bus.res_val & res_bus.res_last;
        end
    end

    assign o_psum     = psum_q;
    assign o_psum_val = psum_val_q;
    assign o_psum_end = psum_end_q;

endmodule

`default_nettype wire

/* hw/weight_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module weight_buffer
    import line_conv_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  weight_word_t                    i_weight,
    engine_ctrl_if.weight                   ctrl_bus,
    output weight_word_t [`LC_NUM_KCPE-1:0] o_pos_weight
);

    weight_word_t [`LC_NUM_KCPE-1:0] pos_weight_q;

    // Word j lands at position j
    // Positions beyond K stay zero and drop out of the sums
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_weight_q <= '0;
        end else if (ctrl_bus.weight_wr) begin
            for (int j = 0; j < `LC_NUM_KCPE; j++) begin
                if (ctrl_bus.weight_idx == tap_idx_t'(j)) begin
                    pos_weight_q[j] <= i_weight;
                end
            end
        end
    end

    assign o_pos_weight = pos_weight_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the line convolution testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_line_conv -o sim_line_conv

./obj_dir/sim_line_conv +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* verification/line_conv_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module line_conv_sva (
    input logic clk,
    input logic rst,
    input logic i_weight_req,
    input logic i_data_req,
    input logic i_done,
    input logic i_psum_val,
    input logic i_psum_end
);

    // Read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    ////////////////////
    // Request phases

    // Weight load and data stream never overlap
    a_req_excl: assert property (@(posedge clk) disable iff (rst)
        !(i_weight_req && i_data_req))
        else begin
            fail_cnt++;
            $error("weight and data requests high together");
        end

    a_done_quiet: assert property (@(posedge clk) disable iff (rst)
        i_done |-> (!i_weight_req && !i_data_req))
        else begin
            fail_cnt++;
            $error("request high while done is set");
        end

    ////////////////////
    // Output flags

    a_end_val: assert property (@(posedge clk) disable iff (rst)
        i_psum_end |-> i_psum_val)
        else begin
            fail_cnt++;
            $error("line end flag without a valid result");
        end

    // Every control output cleared by a reset edge
    a_reset_clear: assert property (@(posedge clk)
        $past(rst) |-> !(i_weight_req || i_data_req || i_done || i_psum_val || i_psum_end))
        else begin
            fail_cnt++;
            $error("control output high right after reset");
        end

endmodule

bind line_conv_top line_conv_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .i_weight_req (o_weight_req),
    .i_data_req   (o_data_req),
    .i_done       (o_done),
    .i_psum_val   (o_psum_val),
    .i_psum_end   (o_psum_end)
);

`default_nettype wire

/* verification/tb_line_conv.sv */
`timescale 1ns/1ps
`default_nettype none
`include "line_conv_defs.svh"

module tb_line_conv
    import line_conv_pkg::*;
();

    localparam int NUM_ROWS = 5;

    logic         clk = 1'b0;
    logic         rst;
    logic         i_conf_enable;
    tap_idx_t     i_conf_kernel_width;
    line_cnt_t    i_conf_line_width;
    line_cnt_t    i_conf_num_lines;
    weight_word_t i_weight;
    logic         i_weight_val;
    pixel_vec_t   i_data;
    logic         i_data_val;
    logic         o_weight_req;
    logic         o_data_req;
    psum_t        o_psum_kn0;
    psum_t        o_psum_kn1;
    psum_t        o_psum_kn2;
    psum_t        o_psum_kn3;
    logic         o_psum_val;
    logic         o_psum_end;
    logic         o_done;

    ////////////////////
    // Test table of K, W, L, gap enable and expected outputs L*(W-K+1)

    tap_idx_t  row_k     [NUM_ROWS] = '{2'd3, 2'd1, 2'd2, 2'd3, 2'd2};
    line_cnt_t row_w     [NUM_ROWS] = '{8'd8, 8'd5, 8'd6, 8'd7, 8'd4};
    line_cnt_t row_l     [NUM_ROWS] = '{8'd2, 8'd2, 8'd3, 8'd3, 8'd2};
    logic      row_gap   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
    line_cnt_t row_count [NUM_ROWS] = '{8'd12, 8'd10, 8'd15, 8'd15, 8'd6};

    integer       seed = 32'hcd9abb10;
    weight_word_t w_mem [`LC_NUM_KCPE];
    pixel_vec_t   pix_mem [];
    psum_vec_t    exp_q [$];
    logic         end_q [$];
    psum_vec_t    mon_exp;
    logic         mon_end;
    line_cnt_t    out_cnt;
    int           psum_errs = 0;
    int           flag_errs = 0;
    int           count_errs = 0;
    int           other_errs = 0;

    line_conv_top DUT (.*);

    always #4 clk = ~clk;

    ////////////////////
    // Compare tasks

    task automatic check_psum(input string name, input psum_t got, input psum_t exp);
        if (got !== exp) begin
            psum_errs++;
            $display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input line_cnt_t got, input line_cnt_t exp);
        if (got !== exp) begin
            count_errs++;
            $display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("o_weight_req", o_weight_req, 1'b0);
        check_flag("o_data_req", o_data_req, 1'b0);
        check_flag("o_done", o_done, 1'b0);
        check_flag("o_psum_val", o_psum_val, 1'b0);
        check_flag("o_psum_end", o_psum_end, 1'b0);
    endtask

    ////////////////////
    // Stimulus and reference model

    function automatic logic pick_valid(input logic gap);
        if (!gap) begin
            return 1'b1;
        end
        return logic'($random(seed) & 1);
    endfunction

    task automatic fill_stimulus(input int npix);
        for (int j = 0; j < `LC_NUM_KCPE; j++) begin
            for (int kn = 0; kn < `LC_NUM_KERNEL; kn++) begin
                for (int c = 0; c < `LC_NUM_CHANNEL; c++) begin
                    w_mem[j][kn][c] = pixel_t'($random(seed));
                end
            end
        end
        pix_mem = new[npix];
        for (int p = 0; p < npix; p++) begin
            for (int c = 0; c < `LC_NUM_CHANNEL; c++) begin
                pix_mem[p][c] = pixel_t'($random(seed));
            end
        end
    endtask

    // Sum of w[j][k][c] * x[n-j][c] for every pixel n >= K-1 of a line
    task automatic build_expected(input int k, input int w, input int l);
        psum_vec_t vec;
        int        acc;
        for (int ln = 0; ln < l; ln++) begin
            for (int n = k - 1; n < w; n++) begin
                for (int kn = 0; kn < `LC_NUM_KERNEL; kn++) begin
                    acc = 0;
                    for (int j = 0; j < k; j++) begin
                        for (int c = 0; c < `LC_NUM_CHANNEL; c++) begin
                            acc += int'(w_mem[j][kn][c]) * int'(pix_mem[ln * w + n - j][c]);
                        end
                    end
                    vec[kn] = psum_t'(acc);
                end
                exp_q.push_back(vec);
                end_q.push_back(n == w - 1);
            end
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        i_conf_enable = 1'b0;
        i_weight_val = 1'b0;
        i_data_val = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
    endtask

    ////////////////////
    // Output monitor

    always @(negedge clk) begin
        if (o_psum_val === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Error at %0d ns: a result came out that was not expected", $time);
            end else begin
                mon_exp = exp_q.pop_front();
                mon_end = end_q.pop_front();
                check_psum("o_psum_kn0", o_psum_kn0, mon_exp[0]);
                check_psum("o_psum_kn1", o_psum_kn1, mon_exp[1]);
                check_psum("o_psum_kn2", o_psum_kn2, mon_exp[2]);
                check_psum("o_psum_kn3", o_psum_kn3, mon_exp[3]);
                check_flag("o_psum_end", o_psum_end, mon_end);
            end
            out_cnt = out_cnt + 1'b1;
        end
    end

    ////////////////////
    // One table row

    task automatic run_row(input int r);
        int widx;
        int pidx;
        int npix;
        npix = int'(row_w[r]) * int'(row_l[r]);
        fill_stimulus(npix);
        exp_q.delete();
        end_q.delete();
        build_expected(int'(row_k[r]), int'(row_w[r]), int'(row_l[r]));
        out_cnt = '0;

        i_conf_kernel_width = row_k[r];
        i_conf_line_width = row_w[r];
        i_conf_num_lines = row_l[r];
        apply_reset();

        // Valids held high before the start must be ignored
        i_weight = w_mem[0];
        i_data = pix_mem[0];
        i_weight_val = 1'b1;
        i_data_val = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        i_conf_enable = 1'b1;
        @(negedge clk);
        check_flag("o_weight_req", o_weight_req, 1'b1);

        widx = 0;
        while (widx < int'(row_k[r])) begin
            i_weight = w_mem[widx];
            i_weight_val = pick_valid(row_gap[r]);
            check_flag("o_data_req", o_data_req, 1'b0);
            if (o_weight_req && i_weight_val) begin
                widx++;
            end
            @(negedge clk);
        end
        check_flag("o_weight_req", o_weight_req, 1'b0);
        check_flag("o_data_req", o_data_req, 1'b1);
        i_weight_val = 1'b1;

        pidx = 0;
        while (pidx < npix) begin
            i_data = pix_mem[pidx];
            i_data_val = pick_valid(row_gap[r]);
            if (o_data_req && i_data_val) begin
                pidx++;
            end
            @(negedge clk);
        end

        // Done holds and nothing more comes out with both valids up
        i_data_val = 1'b1;
        repeat (6) begin
            check_flag("o_done", o_done, 1'b1);
            check_flag("o_data_req", o_data_req, 1'b0);
            check_flag("o_weight_req", o_weight_req, 1'b0);
            @(negedge clk);
        end
        check_count("o_psum_val count", out_cnt, row_count[r]);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("Error: %0d expected results never came out", exp_q.size());
        end
        $display("Row %0d done: K=%0d W=%0d L=%0d", r, row_k[r], row_w[r], row_l[r]);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        int total;
        rst = 1'b1;
        i_conf_enable = 1'b0;
        i_conf_kernel_width = '0;
        i_conf_line_width = '0;
        i_conf_num_lines = '0;
        i_weight = '0;
        i_weight_val = 1'b0;
        i_data = '0;
        i_data_val = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        total = psum_errs + flag_errs + count_errs + other_errs + int'(DUT.u_sva.fail_cnt);
        $display("Errors: psum %0d, flag %0d, count %0d, other %0d, assertion %0d",
                 psum_errs, flag_errs, count_errs, other_errs, DUT.u_sva.fail_cnt);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Budget of four cycles per word and pixel plus slack per row
    initial begin
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += (int'(row_k[r]) + int'(row_w[r]) * int'(row_l[r])) * 4 + 100;
        end
        #(limit * 8);
        $display("Watchdog expired after %0d cycles, the test did not finish", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
